/* design/membus_pkg.sv */
// Bus widths, address map, region code and boot ROM contents rule

package membus_pkg;

    // ----------------------------------------
    // Bus widths
    // ----------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = DATA_W / 8;

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    localparam logic [ADDR_W-1:0] ROM_BASE  = 32'h0001_0000;
    localparam int                ROM_WORDS = 256;
    localparam int                ROM_IDX_W = $clog2(ROM_WORDS);
    localparam logic [ADDR_W-1:0] ROM_END   = ROM_BASE + 4 * ROM_WORDS;

    localparam logic [ADDR_W-1:0] RAM_BASE  = 32'h8000_0000;
    localparam int                RAM_WORDS = 1024;
    localparam int                RAM_IDX_W = $clog2(RAM_WORDS);
    localparam logic [ADDR_W-1:0] RAM_END   = RAM_BASE + 4 * RAM_WORDS;

    // Fills the upper half of every ROM word
    localparam logic [15:0] ROM_TAG = 16'hb007;

    typedef enum logic [1:0] {
        REGION_NONE = 2'd0,
        REGION_ROM  = 2'd1,
        REGION_RAM  = 2'd2
    } region_e;

    // Window lookup, byte offset bits do not matter
    function automatic region_e addr_region(input logic [ADDR_W-1:0] adr);
        if (adr >= ROM_BASE && adr < ROM_END) return REGION_ROM;
        if (adr >= RAM_BASE && adr < RAM_END) return REGION_RAM;
        return REGION_NONE;
    endfunction

    // Tag on top, word index below
    function automatic logic [DATA_W-1:0] rom_word(input logic [ROM_IDX_W-1:0] idx);
        return {ROM_TAG, 16'(idx)};
    endfunction

endpackage

/* design/wb_if.sv */
// Wishbone classic bus interface with master and slave modports

`timescale 1ns/100ps

interface wb_if;

    // Request side, owned by the master
    logic                            cyc;
    logic                            stb;
    logic                            we;
    logic [membus_pkg::ADDR_W-1:0]   adr;
    logic [membus_pkg::DATA_W-1:0]   dat_w;
    logic [membus_pkg::SEL_W-1:0]    sel;

    // Reply side, owned by the slave
    logic [membus_pkg::DATA_W-1:0]   dat_r;
    logic                            ack;
    logic                            err;

    modport master (
        output cyc,
        output stb,
        output we,
        output adr,
        output dat_w,
        output sel,
        input  dat_r,
        input  ack,
        input  err
    );

    modport slave (
        input  cyc,
        input  stb,
        input  we,
        input  adr,
        input  dat_w,
        input  sel,
        output dat_r,
        output ack,
        output err
    );

endinterface

/* design/wb_addr_decode.sv */
// Address decoder with request steering, unmapped error reply and response combiner

`timescale 1ns/100ps

module wb_addr_decode (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic                            cyc_i,
    input  logic                            stb_i,
    input  logic                            we_i,
    input  logic [membus_pkg::ADDR_W-1:0]   adr_i,
    input  logic [membus_pkg::DATA_W-1:0]   dat_i,
    input  logic [membus_pkg::SEL_W-1:0]    sel_i,
    output logic [membus_pkg::DATA_W-1:0]   dat_o,
    output logic                            ack_o,
    output logic                            err_o,
    wb_if.master                            rom_bus,
    wb_if.master                            ram_bus
);

    membus_pkg::region_e region;
    logic                none_err_q;

    assign region = membus_pkg::addr_region(adr_i);

    // ----------------------------------------
    // Request steering
    // ----------------------------------------
    // Payload goes to both slaves, only strobes are steered
    assign rom_bus.we    = we_i;
    assign rom_bus.adr   = adr_i;
    assign rom_bus.dat_w = dat_i;
    assign rom_bus.sel   = sel_i;

    assign ram_bus.we    = we_i;
    assign ram_bus.adr   = adr_i;
    assign ram_bus.dat_w = dat_i;
    assign ram_bus.sel   = sel_i;

    always_comb begin
        rom_bus.cyc = 1'b0;
        rom_bus.stb = 1'b0;
        ram_bus.cyc = 1'b0;
        ram_bus.stb = 1'b0;
        case (region)
            membus_pkg::REGION_ROM: begin
                rom_bus.cyc = cyc_i;
                rom_bus.stb = stb_i;
            end
            membus_pkg::REGION_RAM: begin
                ram_bus.cyc = cyc_i;
                ram_bus.stb = stb_i;
            end
            default: begin
            end
        endcase
    end

    // ----------------------------------------
    // Unmapped error reply
    // ----------------------------------------
    // Same one cycle latency as the slaves
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            none_err_q <= 1'b0;
        end else begin
            none_err_q <= cyc_i && stb_i && (region == membus_pkg::REGION_NONE)
                          && !none_err_q;
        end
    end

    // ----------------------------------------
    // Response combiner
    // ----------------------------------------
    assign ack_o = rom_bus.ack | ram_bus.ack;
    assign err_o = rom_bus.err | ram_bus.err | none_err_q;

    // Read data only while the selected slave acks, zero otherwise
    always_comb begin
        dat_o = '0;
        case (region)
            membus_pkg::REGION_ROM: if (rom_bus.ack) dat_o = rom_bus.dat_r;
            membus_pkg::REGION_RAM: if (ram_bus.ack) dat_o = ram_bus.dat_r;
            default: dat_o = '0;
        endcase
    end

    a_reply_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ack_o && err_o))
        else $error("ack and err high together");

    a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(rom_bus.stb && ram_bus.stb))
        else $error("both slave buses strobed");

endmodule

/* design/wb_bootrom.sv */
// Boot ROM slave with registered read reply and write rejection

`timescale 1ns/100ps

module wb_bootrom (
    input  logic  clk_i,
    input  logic  rst_n_i,
    wb_if.slave   bus
);

    logic                                 ack_q;
    logic                                 err_q;
    logic [membus_pkg::DATA_W-1:0]        rd_q;
    logic [membus_pkg::ROM_IDX_W-1:0]     idx;
    logic                                 req;

    // Word index within the window
    assign idx = bus.adr[2 +: membus_pkg::ROM_IDX_W];

    // No new request while a reply is out
    assign req = bus.cyc && bus.stb && !ack_q && !err_q;

    // ----------------------------------------
    // Reply handshake
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= req && !bus.we;
            // Writes are refused
            err_q <= req && bus.we;
        end
    end

    // Contents come from the package rule
    always_ff @(posedge clk_i) begin
        if (req && !bus.we) begin
            rd_q <= membus_pkg::rom_word(idx);
        end
    end

    assign bus.ack   = ack_q;
    assign bus.err   = err_q;
    assign bus.dat_r = rd_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_rom_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(bus.ack && bus.err))
        else $error("ROM ack and err together");

    a_rom_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(bus.ack || bus.err) |-> $past(bus.cyc && bus.stb))
        else $error("ROM reply without a strobe");

    // Decoder must only strobe inside the ROM window
    a_rom_window: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bus.cyc && bus.stb) |-> membus_pkg::addr_region(bus.adr) == membus_pkg::REGION_ROM)
        else $error("ROM strobed outside its window");

endmodule

/* design/wb_sram.sv */
// Byte-writable SRAM slave with one wait state

`timescale 1ns/100ps

module wb_sram (
    input  logic  clk_i,
    input  logic  rst_n_i,
    wb_if.slave   bus
);

    logic [membus_pkg::DATA_W-1:0]     mem [membus_pkg::RAM_WORDS];
    logic [membus_pkg::DATA_W-1:0]     rd_q;
    logic [membus_pkg::RAM_IDX_W-1:0]  idx;
    logic                              ack_q;
    logic                              req;

    assign idx = bus.adr[2 +: membus_pkg::RAM_IDX_W];

    // Held strobe is ignored while ack is out
    assign req = bus.cyc && bus.stb && !ack_q;

    // ----------------------------------------
    // Handshake
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // ----------------------------------------
    // Word array
    // ----------------------------------------
    // Cleared on reset so unwritten words read as zero
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int w = 0; w < membus_pkg::RAM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (req && bus.we) begin
            for (int b = 0; b < membus_pkg::SEL_W; b++) begin
                if (bus.sel[b]) begin
                    mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
                end
            end
        end
    end

    // Full word on reads, sel plays no part
    always_ff @(posedge clk_i) begin
        if (req && !bus.we) begin
            rd_q <= mem[idx];
        end
    end

    assign bus.ack   = ack_q;
    // Every mapped RAM access succeeds
    assign bus.err   = 1'b0;
    assign bus.dat_r = rd_q;

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    a_ram_single_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bus.ack |=> !bus.ack)
        else $error("SRAM ack held two cycles");

    a_ram_window: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (bus.cyc && bus.stb) |-> membus_pkg::addr_region(bus.adr) == membus_pkg::REGION_RAM)
        else $error("SRAM strobed outside its window");

endmodule

/* design/membus_top.sv */
// Memory subsystem top with decoder, boot ROM and SRAM behind one Wishbone port

`timescale 1ns/100ps

module membus_top (
    input  logic                            clk_i,
    input  logic                            rst_n_i,

    // Wishbone port from the core or debug host
    input  logic                            wb_cyc_i,
    input  logic                            wb_stb_i,
    input  logic                            wb_we_i,
    input  logic [membus_pkg::ADDR_W-1:0]   wb_adr_i,
    input  logic [membus_pkg::DATA_W-1:0]   wb_dat_i,
    input  logic [membus_pkg::SEL_W-1:0]    wb_sel_i,
    output logic [membus_pkg::DATA_W-1:0]   wb_dat_o,
    output logic                            wb_ack_o,
    output logic                            wb_err_o
);

    wb_if rom_bus ();
    wb_if ram_bus ();

    // ----------------------------------------
    // Decoder
    // ----------------------------------------
    wb_addr_decode i_decode (
        .clk_i   ( clk_i    ),
        .rst_n_i ( rst_n_i  ),
        .cyc_i   ( wb_cyc_i ),
        .stb_i   ( wb_stb_i ),
        .we_i    ( wb_we_i  ),
        .adr_i   ( wb_adr_i ),
        .dat_i   ( wb_dat_i ),
        .sel_i   ( wb_sel_i ),
        .dat_o   ( wb_dat_o ),
        .ack_o   ( wb_ack_o ),
        .err_o   ( wb_err_o ),
        .rom_bus ( rom_bus  ),
        .ram_bus ( ram_bus  )
    );

    // ----------------------------------------
    // Boot ROM
    // ----------------------------------------
    wb_bootrom i_bootrom (
        .clk_i   ( clk_i   ),
        .rst_n_i ( rst_n_i ),
        .bus     ( rom_bus )
    );

    // ----------------------------------------
    // SRAM
    // ----------------------------------------
    wb_sram i_sram (
        .clk_i   ( clk_i   ),
        .rst_n_i ( rst_n_i ),
        .bus     ( ram_bus )
    );

endmodule

/* test/membus_tb.sv */
// Testbench for the memory subsystem with LFSR stimulus, SRAM shadow model and reply checks

`timescale 1ns/100ps

module membus_tb;

    logic                            clk_i;
    logic                            rst_n_i;
    logic                            wb_cyc_i;
    logic                            wb_stb_i;
    logic                            wb_we_i;
    logic [membus_pkg::ADDR_W-1:0]   wb_adr_i;
    logic [membus_pkg::DATA_W-1:0]   wb_dat_i;
    logic [membus_pkg::SEL_W-1:0]    wb_sel_i;
    logic [membus_pkg::DATA_W-1:0]   wb_dat_o;
    logic                            wb_ack_o;
    logic                            wb_err_o;

    logic [31:0]                     lfsr_q;
    logic [membus_pkg::DATA_W-1:0]   shadow [membus_pkg::RAM_WORDS];

    // Expected and observed reply of the transfer in flight
    logic [31:0]                     exp_data;
    logic                            exp_ack;
    logic                            exp_err;
    logic                            exp_has_data;
    logic [31:0]                     got_data;
    logic                            got_ack;
    logic                            got_err;
    int                              got_cycles;
    event                            reply_ev;

    int                              total_errors;
    int                              test_errors;
    int                              tests_run;
    int                              tests_failed;
    int                              checks;

    membus_top i_dut (
        .clk_i    ( clk_i    ),
        .rst_n_i  ( rst_n_i  ),
        .wb_cyc_i ( wb_cyc_i ),
        .wb_stb_i ( wb_stb_i ),
        .wb_we_i  ( wb_we_i  ),
        .wb_adr_i ( wb_adr_i ),
        .wb_dat_i ( wb_dat_i ),
        .wb_sel_i ( wb_sel_i ),
        .wb_dat_o ( wb_dat_o ),
        .wb_ack_o ( wb_ack_o ),
        .wb_err_o ( wb_err_o )
    );

    always #4 clk_i = ~clk_i;

    // ----------------------------------------
    // Random numbers and reference model
    // ----------------------------------------
    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // Unsigned wrap makes addresses below a base fall outside
    function automatic membus_pkg::region_e window_of(input logic [31:0] adr);
        if ((adr - membus_pkg::ROM_BASE) < 32'(4 * membus_pkg::ROM_WORDS)) begin
            return membus_pkg::REGION_ROM;
        end
        if ((adr - membus_pkg::RAM_BASE) < 32'(4 * membus_pkg::RAM_WORDS)) begin
            return membus_pkg::REGION_RAM;
        end
        return membus_pkg::REGION_NONE;
    endfunction

    function automatic void expected_reply(
        input  logic [31:0] adr,
        input  logic        we,
        input  logic [31:0] wdat,
        input  logic [3:0]  sel,
        output logic [31:0] data,
        output logic        ack,
        output logic        err,
        output logic        has_data
    );
        logic [31:0] offset;
        int          idx;
        data     = '0;
        ack      = 1'b0;
        err      = 1'b0;
        has_data = 1'b1;
        case (window_of(adr))
            membus_pkg::REGION_ROM: begin
                offset = adr - membus_pkg::ROM_BASE;
                if (we) begin
                    err = 1'b1;
                end else begin
                    ack  = 1'b1;
                    data = {membus_pkg::ROM_TAG, 16'(offset >> 2)};
                end
            end
            membus_pkg::REGION_RAM: begin
                offset = adr - membus_pkg::RAM_BASE;
                idx    = int'(offset >> 2);
                ack    = 1'b1;
                if (we) begin
                    // Write replies carry no defined data
                    has_data = 1'b0;
                    for (int b = 0; b < membus_pkg::SEL_W; b++) begin
                        if (sel[b]) begin
                            shadow[idx][8*b +: 8] = wdat[8*b +: 8];
                        end
                    end
                end else begin
                    data = shadow[idx];
                end
            end
            default: err = 1'b1;
        endcase
    endfunction

    // ----------------------------------------
    // Checking
    // ----------------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            test_errors++;
            total_errors++;
        end
    endtask

    // Compares each captured reply against the reference
    always @(reply_ev) begin
        if (got_cycles != 1) begin
            $display("Reply came %0d cycles after the strobe instead of one", got_cycles);
            test_errors++;
            total_errors++;
        end
        check_value("wb_ack_o", got_ack, exp_ack);
        check_value("wb_err_o", got_err, exp_err);
        if (exp_has_data) begin
            check_value("wb_dat_o", got_data, exp_data);
        end
    end

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%-18s ok", name);
        end else begin
            $display("%-18s %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // ----------------------------------------
    // Bus driver
    // ----------------------------------------
    // Entered on a falling edge and left after one idle cycle
    task automatic bus_transfer(input logic [31:0] adr, input logic we,
                                input logic [31:0] wdat, input logic [3:0] sel);
        int   n;
        logic seen;
        expected_reply(adr, we, wdat, sel, exp_data, exp_ack, exp_err, exp_has_data);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        wb_sel_i = sel;
        // No reply is due yet in the low phase before the first edge
        #2;
        seen = wb_ack_o || wb_err_o;
        n    = 0;
        if (!seen) begin
            @(posedge clk_i);
        end
        while (!seen && n < 16) begin
            @(negedge clk_i);
            n++;
            seen = wb_ack_o || wb_err_o;
        end
        if (seen) begin
            got_data   = wb_dat_o;
            got_ack    = wb_ack_o;
            got_err    = wb_err_o;
            got_cycles = n;
            -> reply_ev;
        end else begin
            $display("No reply from the DUT within 16 cycles at address %h", adr);
            test_errors++;
            total_errors++;
        end
        // Address stays put so the reply data holds until the edge
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        @(negedge clk_i);
        check_value("wb_ack_o", wb_ack_o, 1'b0);
        check_value("wb_err_o", wb_err_o, 1'b0);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic reset_timing();
        check_value("wb_ack_o", wb_ack_o, 1'b0);
        check_value("wb_err_o", wb_err_o, 1'b0);
        check_value("wb_dat_o", wb_dat_o, 32'h0);
        bus_transfer(membus_pkg::ROM_BASE, 1'b0, 32'h0, 4'hf);
        bus_transfer(membus_pkg::RAM_BASE, 1'b0, 32'h0, 4'hf);
        bus_transfer(32'h0, 1'b0, 32'h0, 4'hf);
        finish_test("reset and timing");
    endtask

    task automatic rom_reads();
        int          fixed_idx [4] = '{0, 1, 128, 255};
        logic [31:0] adr;
        foreach (fixed_idx[i]) begin
            bus_transfer(membus_pkg::ROM_BASE + 4 * fixed_idx[i], 1'b0, 32'h0, 4'hf);
        end
        for (int i = 0; i < 24; i++) begin
            adr = membus_pkg::ROM_BASE + 4 * rand_bits(8);
            // Low address bits must not matter
            adr[1:0] = rand_bits(2);
            bus_transfer(adr, 1'b0, 32'h0, 4'hf);
        end
        finish_test("rom reads");
    endtask

    task automatic rom_protect();
        logic [31:0] adr;
        logic [31:0] wdat;
        for (int i = 0; i < 8; i++) begin
            adr  = (i < 4) ? membus_pkg::ROM_BASE + 4 * (i * 85) :
                             membus_pkg::ROM_BASE + 4 * rand_bits(8);
            wdat = rand_bits(32);
            bus_transfer(adr, 1'b1, wdat, 4'hf);
            bus_transfer(adr, 1'b0, 32'h0, 4'hf);
        end
        finish_test("rom protection");
    endtask

    task automatic sram_bytes();
        logic [31:0] word_adr;
        logic [31:0] wdat;
        for (int s = 0; s < 16; s++) begin
            // One shared word so byte lanes accumulate
            wdat = rand_bits(32);
            bus_transfer(membus_pkg::RAM_BASE + 32'h40, 1'b1, wdat, 4'(s));
            bus_transfer(membus_pkg::RAM_BASE + 32'h40, 1'b0, 32'h0, rand_bits(4));
            // Fresh word per pattern that reads as zero first
            word_adr = membus_pkg::RAM_BASE + 32'h100 + 4 * s;
            wdat     = rand_bits(32);
            bus_transfer(word_adr, 1'b0, 32'h0, 4'hf);
            bus_transfer(word_adr, 1'b1, wdat, 4'(s));
            bus_transfer(word_adr, 1'b0, 32'h0, rand_bits(4));
        end
        word_adr = membus_pkg::RAM_BASE + 4 * (membus_pkg::RAM_WORDS - 1);
        bus_transfer(word_adr, 1'b0, 32'h0, 4'hf);
        bus_transfer(word_adr, 1'b1, 32'hdead_beef, 4'b1001);
        bus_transfer(word_adr, 1'b0, 32'h0, 4'hf);
        finish_test("sram byte writes");
    endtask

    task automatic unmapped_access();
        logic [31:0] edge_adr [6] = '{
            membus_pkg::ROM_BASE - 4,
            membus_pkg::ROM_BASE + 4 * membus_pkg::ROM_WORDS,
            membus_pkg::RAM_BASE - 4,
            membus_pkg::RAM_BASE + 4 * membus_pkg::RAM_WORDS,
            32'h0000_0000,
            32'hffff_fffc
        };
        logic [31:0] probe [$];
        logic [31:0] adr;
        int          tries;
        foreach (edge_adr[i]) begin
            probe.push_back(edge_adr[i]);
        end
        for (int i = 0; i < 12; i++) begin
            tries = 0;
            adr   = rand_bits(32);
            while (window_of(adr) != membus_pkg::REGION_NONE && tries < 8) begin
                adr = rand_bits(32);
                tries++;
            end
            probe.push_back(adr);
        end
        foreach (probe[i]) begin
            bus_transfer(probe[i], 1'b0, 32'h0, 4'hf);
            bus_transfer(probe[i], 1'b1, rand_bits(32), 4'hf);
        end
        // Words the unmapped writes would alias onto
        foreach (probe[i]) begin
            bus_transfer(membus_pkg::RAM_BASE + (probe[i] & 32'h0000_0ffc), 1'b0, 32'h0, 4'hf);
        end
        finish_test("unmapped access");
    endtask

    task automatic random_mix();
        logic [31:0] adr;
        logic [31:0] wdat;
        logic [3:0]  sel;
        logic        we;
        logic [1:0]  kind;
        for (int i = 0; i < 200; i++) begin
            kind = rand_bits(2);
            case (kind)
                2'd0:    adr = membus_pkg::ROM_BASE + 4 * rand_bits(8);
                // Narrow RAM range for read after write hits
                2'd1:    adr = membus_pkg::RAM_BASE + 4 * rand_bits(5);
                2'd2:    adr = membus_pkg::RAM_BASE + 4 * rand_bits(10);
                default: adr = rand_bits(32);
            endcase
            adr[1:0] = rand_bits(2);
            we       = rand_bits(1);
            wdat     = rand_bits(32);
            sel      = rand_bits(4);
            bus_transfer(adr, we, wdat, sel);
        end
        finish_test("random mix");
    endtask

    // ----------------------------------------
    // Sequence
    // ----------------------------------------
    initial begin
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_sel_i     = '0;
        lfsr_q       = 32'h7625_42eb;
        total_errors = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        checks       = 0;
        for (int w = 0; w < membus_pkg::RAM_WORDS; w++) begin
            shadow[w] = '0;
        end
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        reset_timing();
        rom_reads();
        rom_protect();
        sram_bytes();
        unmapped_access();
        random_mix();

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, total_errors);
        if (total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* membus.f */
design/membus_pkg.sv
design/wb_if.sv
design/wb_addr_decode.sv
design/wb_bootrom.sv
design/wb_sram.sv
design/membus_top.sv
test/membus_tb.sv
